// File: Makefile
# Verilator flow for the game screens testbench

VERILATOR ?= verilator
TOP       ?= game_screens_tb
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_STR  ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
source/game_pkg.sv
source/link_pkg.sv
source/tetromino_cells.sv
source/top_out_detect.sv
source/game_screens_fsm.sv
source/opponent_link_wb.sv
source/game_screens_top.sv
verification/game_screens_sva.sv
verification/game_screens_tb.sv

// File: source/game_pkg.sv
package game_pkg;

    // Seven standard pieces
    typedef enum logic [2:0] {
        PIECE_I = 3'd0,
        PIECE_O = 3'd1,
        PIECE_T = 3'd2,
        PIECE_S = 3'd3,
        PIECE_Z = 3'd4,
        PIECE_J = 3'd5,
        PIECE_L = 3'd6
    } piece_type_t;

    typedef enum logic [1:0] {
        R0   = 2'd0,                   // Spawn orientation
        R90  = 2'd1,                   // Clockwise steps from here on
        R180 = 2'd2,
        R270 = 2'd3
    } orientation_t;

    typedef struct packed {
        logic         valid;           // Lock strobe
        logic [4:0]   row;             // Box origin, top-left
        logic [4:0]   col;
        piece_type_t  piece;
        orientation_t orient;
    } piece_lock_t;

    typedef struct packed {
        logic            valid;
        logic [3:0][4:0] row;          // One entry per cell
        logic [3:0][4:0] col;
    } cell_set_t;

    typedef enum logic [2:0] {
        START_SCREEN = 3'd0,
        SPRINT_MODE  = 3'd1,
        MP_READY     = 3'd2,
        MP_MODE      = 3'd3,
        GAME_WON     = 3'd4,
        GAME_LOST    = 3'd5
    } game_screen_t;

    localparam logic [4:0] PLAYFIELD_ROWS = 5'd20;  // Visible rows 0..19, top down

endpackage

// File: source/game_screens_fsm.sv
`timescale 1ns/1ps

module game_screens_fsm #(
    parameter logic [5:0] sprint_lines = 6'd40     // Lines to win sprint
) (
    input  logic                   clk,
    input  logic                   rst_l,
    input  logic                   top_out,
    input  logic [5:0]             lines_cleared,
    input  logic                   start_sprint,
    input  logic                   battle_ready,
    input  logic                   ready_withdraw,
    input  logic                   opponent_ready,
    input  logic                   opponent_lost,
    output logic                   game_start,
    output logic                   game_end,
    output game_pkg::game_screen_t current_screen
);
    import game_pkg::*;

    game_screen_t state;
    game_screen_t next_state;
    logic         start_nxt;           // Pulses staged with the state change
    logic         end_nxt;

    always_comb begin
        next_state = state;
        start_nxt  = 1'b0;
        end_nxt    = 1'b0;
        case (state)
            START_SCREEN: begin
                if (start_sprint) begin
                    next_state = SPRINT_MODE;
                    start_nxt  = 1'b1;
                end else if (battle_ready) begin
                    next_state = MP_READY;     // Wait for the opponent
                end
            end
            SPRINT_MODE: begin
                if (top_out) begin
                    next_state = GAME_LOST;    // Loss wins the tie
                    end_nxt    = 1'b1;
                end else if (lines_cleared >= sprint_lines) begin
                    next_state = GAME_WON;
                    end_nxt    = 1'b1;
                end
            end
            MP_READY: begin
                if (opponent_ready) begin
                    next_state = MP_MODE;
                    start_nxt  = 1'b1;
                end else if (ready_withdraw) begin
                    next_state = START_SCREEN;
                end
            end
            MP_MODE: begin
                if (top_out) begin
                    next_state = GAME_LOST;
                    end_nxt    = 1'b1;
                end else if (opponent_lost) begin
                    next_state = GAME_WON;     // Opponent topped out
                    end_nxt    = 1'b1;
                end
            end
            GAME_WON, GAME_LOST: begin
                if (start_sprint || battle_ready) begin
                    next_state = START_SCREEN; // Any button leaves the end screen
                end
            end
            default: next_state = START_SCREEN;   // Illegal codes recover
        endcase
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            state      <= START_SCREEN;
            game_start <= 1'b0;
            game_end   <= 1'b0;
        end else begin
            state      <= next_state;
            game_start <= start_nxt;
            game_end   <= end_nxt;
        end
    end

    assign current_screen = state;

endmodule

// File: source/game_screens_top.sv
`timescale 1ns/1ps

module game_screens_top #(
    parameter logic [5:0] sprint_lines = 6'd40
) (
    input  logic                   clk,
    input  logic                   rst_l,
    input  game_pkg::piece_lock_t  lock,
    input  logic [5:0]             lines_cleared,
    input  logic                   start_sprint,
    input  logic                   battle_ready,
    input  logic                   ready_withdraw,
    input  link_pkg::wb_req_t      wb_req,
    output link_pkg::wb_rsp_t      wb_rsp,
    output logic                   top_out,
    output logic                   game_start,
    output logic                   game_end,
    output game_pkg::game_screen_t current_screen
);
    import game_pkg::*;

    cell_set_t cells;                  // Stage 1 to stage 2
    logic      opponent_ready;         // Link level into the FSM
    logic      opponent_lost;          // Link pulse into the FSM

    tetromino_cells u_cells (
        .clk   (clk),
        .rst_l (rst_l),
        .lock  (lock),
        .cells (cells)
    );

    top_out_detect u_top_out (
        .clk     (clk),
        .rst_l   (rst_l),
        .cells   (cells),
        .top_out (top_out)
    );

    game_screens_fsm #(
        .sprint_lines (sprint_lines)
    ) u_fsm (
        .clk            (clk),
        .rst_l          (rst_l),
        .top_out        (top_out),
        .lines_cleared  (lines_cleared),
        .start_sprint   (start_sprint),
        .battle_ready   (battle_ready),
        .ready_withdraw (ready_withdraw),
        .opponent_ready (opponent_ready),
        .opponent_lost  (opponent_lost),
        .game_start     (game_start),
        .game_end       (game_end),
        .current_screen (current_screen)
    );

    opponent_link_wb u_link (
        .clk            (clk),
        .rst_l          (rst_l),
        .wb_req         (wb_req),
        .wb_rsp         (wb_rsp),
        .current_screen (current_screen),
        .local_lost     (top_out),
        .opponent_ready (opponent_ready),
        .opponent_lost  (opponent_lost)
    );

endmodule

// File: source/link_pkg.sv
package link_pkg;

    // Master to slave, classic cycle
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [1:0] adr;               // Register index
        logic [7:0] dat;               // Write data
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic       ack;
        logic [7:0] dat;               // Read data, valid with ack
    } wb_rsp_t;

    // Ctrl write: bit 0 ready level, bit 1 lost pulse
    localparam logic [1:0] LINK_CTRL_ADR = 2'd0;

    // Stat read: {opp ready, local top out, screen[2:0]}
    localparam logic [1:0] LINK_STAT_ADR = 2'd1;

    localparam int CTRL_READY_BIT = 0;
    localparam int CTRL_LOST_BIT  = 1;

endpackage

// File: source/opponent_link_wb.sv
`timescale 1ns/1ps

module opponent_link_wb (
    input  logic                   clk,
    input  logic                   rst_l,
    input  link_pkg::wb_req_t      wb_req,
    output link_pkg::wb_rsp_t      wb_rsp,
    input  game_pkg::game_screen_t current_screen,
    input  logic                   local_lost,     // Top-out pulse
    output logic                   opponent_ready,
    output logic                   opponent_lost
);
    import game_pkg::*;
    import link_pkg::*;

    logic       req;                   // Live request
    logic       ack;
    logic       ctrl_wr;
    logic       lost_flag;             // Sticky local top out
    logic [7:0] status;
    logic [7:0] rd_dat;

    assign req     = wb_req.cyc && wb_req.stb;
    assign ctrl_wr = req && !ack && wb_req.we && (wb_req.adr == LINK_CTRL_ADR);
    assign status  = {3'b000, opponent_ready, lost_flag, current_screen};

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            ack            <= 1'b0;
            opponent_ready <= 1'b0;
            opponent_lost  <= 1'b0;
            lost_flag      <= 1'b0;
        end else begin
            ack           <= req && !ack;  // One cycle high, then drop
            opponent_lost <= ctrl_wr && wb_req.dat[CTRL_LOST_BIT];
            if (ctrl_wr) begin
                opponent_ready <= wb_req.dat[CTRL_READY_BIT];  // Level, set or clear
            end
            if (current_screen == START_SCREEN) begin
                lost_flag <= 1'b0;     // Fresh round
            end else if (local_lost) begin
                lost_flag <= 1'b1;
            end
        end
    end

    // Read data captured with the ack edge
    always_ff @(posedge clk) begin
        if (req && !ack) begin
            rd_dat <= (wb_req.adr == LINK_STAT_ADR) ? status : 8'h00;
        end
    end

    assign wb_rsp = '{ack: ack, dat: rd_dat};

endmodule

// File: source/tetromino_cells.sv
`timescale 1ns/1ps

module tetromino_cells (
    input  logic                  clk,
    input  logic                  rst_l,
    input  game_pkg::piece_lock_t lock,
    output game_pkg::cell_set_t   cells
);
    import game_pkg::*;

    logic [3:0][3:0] offs;             // Per cell {row[1:0], col[1:0]} in the box
    logic [3:0][4:0] row_sum;
    logic [3:0][4:0] col_sum;
    logic            cell_valid;
    logic [3:0][4:0] cell_row;
    logic [3:0][4:0] cell_col;

    // Shape table at R0, cells as {row, col}
    function automatic logic [3:0][3:0] shape_of(piece_type_t p);
        case (p)
            PIECE_I: shape_of = {4'b01_00, 4'b01_01, 4'b01_10, 4'b01_11};
            PIECE_O: shape_of = {4'b00_01, 4'b00_10, 4'b01_01, 4'b01_10};
            PIECE_T: shape_of = {4'b00_01, 4'b01_00, 4'b01_01, 4'b01_10};
            PIECE_S: shape_of = {4'b00_01, 4'b00_10, 4'b01_00, 4'b01_01};
            PIECE_Z: shape_of = {4'b00_00, 4'b00_01, 4'b01_01, 4'b01_10};
            PIECE_J: shape_of = {4'b00_00, 4'b01_00, 4'b01_01, 4'b01_10};
            PIECE_L: shape_of = {4'b00_10, 4'b01_00, 4'b01_01, 4'b01_10};
            default: shape_of = '0;    // Unused code
        endcase
    endfunction

    // Quarter turn clockwise, (r, c) -> (c, 3 - r)
    function automatic logic [3:0] rot_cw(logic [3:0] rc);
        rot_cw = {rc[1:0], 2'd3 - rc[3:2]};
    endfunction

    always_comb begin
        offs = shape_of(lock.piece);
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < 3; k++) begin
                if (k < int'(lock.orient)) begin
                    offs[i] = rot_cw(offs[i]);     // Up to three turns
                end
            end
            row_sum[i] = lock.row + {3'b000, offs[i][3:2]};  // Mod 32, above top wraps high
            col_sum[i] = lock.col + {3'b000, offs[i][1:0]};
        end
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            cell_valid <= 1'b0;
        end else begin
            cell_valid <= lock.valid;
        end
    end

    // Payload only loads on a lock
    always_ff @(posedge clk) begin
        if (lock.valid) begin
            cell_row <= row_sum;
            cell_col <= col_sum;
        end
    end

    assign cells = '{valid: cell_valid, row: cell_row, col: cell_col};

endmodule

// File: source/top_out_detect.sv
`timescale 1ns/1ps

module top_out_detect (
    input  logic                clk,
    input  logic                rst_l,
    input  game_pkg::cell_set_t cells,
    output logic                top_out
);
    import game_pkg::*;

    logic any_high;                    // Some cell at or past the floor count

    // Wrapped rows from above the top also land here
    always_comb begin
        any_high = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (cells.row[i] >= PLAYFIELD_ROWS) begin
                any_high = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            top_out <= 1'b0;
        end else begin
            top_out <= cells.valid && any_high;  // One pulse per bad lock
        end
    end

endmodule

// File: verification/game_screens_sva.sv
`timescale 1ns/1ps

module game_screens_sva (
    input logic              clk,
    input logic              rst_l,
    input link_pkg::wb_req_t wb_req,
    input link_pkg::wb_rsp_t wb_rsp
);
    logic req;

    assign req = wb_req.cyc && wb_req.stb;   // Classic request

    ack_follows_req: assert property (
        @(posedge clk) disable iff (!rst_l) req && !wb_rsp.ack |=> wb_rsp.ack
    ) else $error("ack did not follow the request by one cycle");

    ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_l) wb_rsp.ack |-> req
    ) else $error("ack high without cyc and stb");

    ack_single: assert property (
        @(posedge clk) disable iff (!rst_l) wb_rsp.ack |=> !wb_rsp.ack
    ) else $error("ack held for two cycles");

endmodule

bind opponent_link_wb game_screens_sva sva0 (
    .clk    (clk),
    .rst_l  (rst_l),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
);

// File: verification/game_screens_tb.sv
`timescale 1ns/1ps

module game_screens_tb;
    import game_pkg::*;
    import link_pkg::*;

    localparam int NUM_LOCKS    = 400;
    localparam int CYCLE_LIMIT  = 3 * NUM_LOCKS + 800;  // Random locks plus screen tests
    localparam int BTN_SPRINT   = 0;
    localparam int BTN_BATTLE   = 1;
    localparam int BTN_WITHDRAW = 2;

    logic         clk;
    logic         rst_l;
    piece_lock_t  lock;
    logic [5:0]   lines_cleared;
    logic         start_sprint;
    logic         battle_ready;
    logic         ready_withdraw;
    wb_req_t      wb_req;
    wb_rsp_t      wb_rsp;
    logic         top_out;
    logic         game_start;
    logic         game_end;
    game_screen_t current_screen;

    logic         m_top1;              // Model, floor reached after stage 1
    logic         m_top_out;
    logic         m_ack;
    logic         m_wr;                // Ctrl write lands on this edge
    logic         m_opp_ready;
    logic         m_opp_lost;
    logic         m_lost;              // Sticky local top out
    logic         m_start;
    logic         m_end;
    game_screen_t m_screen;
    int           errors;              // Task failures
    int           cmp_errors;          // Compare process failures
    int           checks;
    int           cycles;
    logic [7:0]   rdat;

    game_screens_top #(
        .sprint_lines (6'd40)
    ) dut0 (
        .clk            (clk),
        .rst_l          (rst_l),
        .lock           (lock),
        .lines_cleared  (lines_cleared),
        .start_sprint   (start_sprint),
        .battle_ready   (battle_ready),
        .ready_withdraw (ready_withdraw),
        .wb_req         (wb_req),
        .wb_rsp         (wb_rsp),
        .top_out        (top_out),
        .game_start     (game_start),
        .game_end       (game_end),
        .current_screen (current_screen)
    );

    // Cells from a 4x4 box mask, bit r*4+c, turned clockwise per step
    function automatic cell_set_t cells_ref(input piece_lock_t pl);
        logic [15:0] box;
        cell_set_t   cs;
        int          n;
        int          r;
        int          c;
        int          t;
        case (pl.piece)
            PIECE_I: box = 16'h00F0;
            PIECE_O: box = 16'h0066;
            PIECE_T: box = 16'h0072;
            PIECE_S: box = 16'h0036;
            PIECE_Z: box = 16'h0063;
            PIECE_J: box = 16'h0071;
            PIECE_L: box = 16'h0074;
            default: box = 16'h0000;
        endcase
        cs = '0;
        cs.valid = pl.valid;
        n = 0;
        for (int i = 0; i < 16; i++) begin
            if (box[i] && n < 4) begin
                r = i / 4;
                c = i % 4;
                for (int k = 0; k < int'(pl.orient); k++) begin
                    t = r;                 // (r, c) -> (c, 3 - r)
                    r = c;
                    c = 3 - t;
                end
                cs.row[n] = 5'(int'(pl.row) + r);  // Mod 32
                cs.col[n] = 5'(int'(pl.col) + c);
                n++;
            end
        end
        return cs;
    endfunction

    function automatic logic reaches_floor(input cell_set_t cs);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (cs.row[i] >= 5'd20) begin
                hit = 1'b1;                // Row 20 and up is off the field
            end
        end
        return hit;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    assign m_wr = wb_req.cyc && wb_req.stb && !m_ack && wb_req.we && wb_req.adr == LINK_CTRL_ADR;

    // Reference model, sees inputs as the DUT samples them
    always @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            {m_top1, m_top_out, m_ack, m_opp_ready, m_opp_lost, m_lost, m_start, m_end} <= '0;
            m_screen <= START_SCREEN;
        end else begin
            m_top1     <= lock.valid && reaches_floor(cells_ref(lock));
            m_top_out  <= m_top1;
            m_ack      <= wb_req.cyc && wb_req.stb && !m_ack;
            m_opp_lost <= m_wr && wb_req.dat[1];
            m_start    <= 1'b0;
            m_end      <= 1'b0;
            if (m_wr) begin
                m_opp_ready <= wb_req.dat[0];
            end
            if (m_screen == START_SCREEN) begin
                m_lost <= 1'b0;
            end else if (m_top_out) begin
                m_lost <= 1'b1;
            end
            case (m_screen)
                START_SCREEN: begin
                    if (start_sprint) begin
                        m_screen <= SPRINT_MODE;
                        m_start  <= 1'b1;
                    end else if (battle_ready) begin
                        m_screen <= MP_READY;
                    end
                end
                SPRINT_MODE, MP_MODE: begin
                    if (m_top_out) begin
                        m_screen <= GAME_LOST;
                        m_end    <= 1'b1;
                    end else if ((m_screen == SPRINT_MODE) ? (lines_cleared >= 6'd40)
                                                           : m_opp_lost) begin
                        m_screen <= GAME_WON;
                        m_end    <= 1'b1;
                    end
                end
                MP_READY: begin
                    if (m_opp_ready) begin
                        m_screen <= MP_MODE;
                        m_start  <= 1'b1;
                    end else if (ready_withdraw) begin
                        m_screen <= START_SCREEN;
                    end
                end
                default: begin
                    if (start_sprint || battle_ready) begin
                        m_screen <= START_SCREEN;   // Leave an end screen
                    end
                end
            endcase
        end
    end

    // Outputs settle by the falling edge
    always @(negedge clk) begin
        if (rst_l) begin
            checks++;
            if (top_out !== m_top_out) begin
                cmp_errors++;
                $display("ERR %0t: top_out %b, expected %b", $time, top_out, m_top_out);
            end
            if (current_screen !== m_screen) begin
                cmp_errors++;
                $display("ERR %0t: screen %s, expected %s", $time, current_screen.name(),
                         m_screen.name());
            end
            if ({game_start, game_end} !== {m_start, m_end}) begin
                cmp_errors++;
                $display("ERR %0t: start/end %b%b, expected %b%b", $time, game_start,
                         game_end, m_start, m_end);
            end
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                $display("Run stopped at the limit of %0d cycles", CYCLE_LIMIT);
                $display("RESULT: FAIL");
                $finish;
            end
        end
    end

    task automatic press_button(input int which);
        @(posedge clk);
        case (which)
            BTN_SPRINT: start_sprint <= 1'b1;
            BTN_BATTLE: battle_ready <= 1'b1;
            default:    ready_withdraw <= 1'b1;
        endcase
        @(posedge clk);
        start_sprint   <= 1'b0;        // One cycle press
        battle_ready   <= 1'b0;
        ready_withdraw <= 1'b0;
    endtask

    task automatic wait_screen(input game_screen_t want);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (current_screen !== want && n < 10);
        if (current_screen !== want) begin
            errors++;
            $display("Screen %s was not reached within 10 cycles", want.name());
        end
    endtask

    task automatic drop_lock(input logic [4:0] origin, input piece_type_t kind,
                             input orientation_t turn);
        @(posedge clk);
        lock <= '{valid: 1'b1, row: origin, col: 5'd3, piece: kind, orient: turn};
        @(posedge clk);
        lock <= '0;
    endtask

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [7:0] wdat);
        int waits;
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        waits = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (!wb_rsp.ack && waits < 8);
        if (!wb_rsp.ack) begin
            errors++;
            $display("Bus access to address %0d got no ack", adr);
        end else if (waits != 2) begin
            errors++;
            $display("ERR %0t: ack after %0d cycles, expected 2", $time, waits);
        end
        rdat = wb_rsp.dat;
        @(posedge clk);
        wb_req <= '0;                  // Held until ack seen
    endtask

    task automatic check_status;
        logic [7:0] want;
        want = {3'b000, m_opp_ready, m_lost, m_screen};
        wb_access(1'b0, LINK_STAT_ADR, 8'h00);
        if (rdat !== want) begin
            errors++;
            $display("ERR %0t: status %h, expected %h", $time, rdat, want);
        end
    endtask

    initial begin
        void'($urandom(71224));
        errors         = 0;
        cmp_errors     = 0;
        checks         = 0;
        rst_l          <= 1'b0;
        lock           <= '0;
        lines_cleared  <= '0;
        start_sprint   <= 1'b0;
        battle_ready   <= 1'b0;
        ready_withdraw <= 1'b0;
        wb_req         <= '0;
        repeat (2) @(posedge clk);
        rst_l <= 1'b1;

        repeat (NUM_LOCKS) begin       // Any type, turn and origin, back to back
            @(posedge clk);
            lock <= '{valid: ($urandom % 4) != 0, row: 5'($urandom), col: 5'($urandom),
                      piece: piece_type_t'(3'($urandom % 7)),
                      orient: orientation_t'(2'($urandom))};
        end
        @(posedge clk);
        lock <= '0;
        repeat (4) @(posedge clk);

        press_button(BTN_SPRINT);      // Sprint win
        wait_screen(SPRINT_MODE);
        drop_lock(5'd16, PIECE_I, R90);    // Bottom row 19, still inside
        @(posedge clk);
        lines_cleared <= 6'd40;
        wait_screen(GAME_WON);
        @(posedge clk);
        lines_cleared <= '0;
        press_button(BTN_BATTLE);
        wait_screen(START_SCREEN);

        press_button(BTN_SPRINT);      // Sprint loss
        wait_screen(SPRINT_MODE);
        drop_lock(5'd17, PIECE_I, R90);    // Reaches row 20
        wait_screen(GAME_LOST);
        press_button(BTN_SPRINT);
        wait_screen(START_SCREEN);

        press_button(BTN_BATTLE);      // Battle
        wait_screen(MP_READY);
        press_button(BTN_WITHDRAW);
        wait_screen(START_SCREEN);
        press_button(BTN_BATTLE);
        wait_screen(MP_READY);
        check_status;
        wb_access(1'b1, LINK_CTRL_ADR, 8'h01);
        wait_screen(MP_MODE);
        check_status;
        wb_access(1'b1, LINK_CTRL_ADR, 8'h03);
        wait_screen(GAME_WON);
        press_button(BTN_SPRINT);
        wait_screen(START_SCREEN);
        press_button(BTN_BATTLE);
        wait_screen(MP_MODE);          // Ready level still set
        drop_lock(5'd31, PIECE_T, R0);     // Above the top, wraps to row 31
        wait_screen(GAME_LOST);
        check_status;
        wb_access(1'b1, LINK_CTRL_ADR, 8'h00);
        check_status;
        repeat (4) @(posedge clk);

        $display("Checks: %0d, compare errors: %0d, other errors: %0d",
                 checks, cmp_errors, errors);
        if (errors == 0 && cmp_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
